/* list.f */
+incdir+logic
logic/issue_ctrl_pkg.sv
logic/issue_instr_pkg.sv
logic/issue_ifs.sv
logic/instr_buffer.sv
logic/scoreboard.sv
logic/operand_collector.sv
logic/dispatch_unit.sv
logic/issue_slice.sv
sim/issue_slice_chk.sv
sim/issue_slice_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module issue_slice_tb -o issue_slice_sim
./obj_dir/issue_slice_sim

/* sim/issue_slice_tb.sv */
`include "issue_macros.svh"

module issue_slice_tb;
    import issue_instr_pkg::*;
    import issue_ctrl_pkg::*;

    localparam int XLEN = `ISSUE_XLEN;
    // Budget of about 200 instructions at up to 20 cycles each from decode to writeback
    localparam int MAX_CYCLES = 200 * 20;

    logic            clk = 1'b0;
    logic            rst;
    logic            dec_valid;
    decoded_t        dec_data;
    logic            dec_ready;
    logic            wb_valid = 1'b0;
    wid_t            wb_wid = '0;
    reg_t            wb_rd = '0;
    logic [XLEN-1:0] wb_data = '0;
    logic            alu_credit = 1'b0;
    logic            mul_credit = 1'b0;
    logic            alu_valid;
    logic            mul_valid;
    issued_t         ex_data;

    integer          seed;
    logic            hold_wb;
    int              cycles = 0;
    int              alu_seen = 0;
    int              mul_seen = 0;

    // Architectural state per warp, advanced in decode order
    logic [XLEN-1:0] ref_rf [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS];
    issued_t         exp_q [$];
    // Instructions inside the execution-unit model, with their return cycle
    issued_t         fly_q [$];
    int              fly_due [$];

    issue_slice u_issue_slice (
        .clk        (clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .dec_data   (dec_data),
        .dec_ready  (dec_ready),
        .wb_valid   (wb_valid),
        .wb_wid     (wb_wid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .alu_credit (alu_credit),
        .mul_credit (mul_credit),
        .alu_valid  (alu_valid),
        .mul_valid  (mul_valid),
        .ex_data    (ex_data)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run("a checked value differs from the expected one");
        end
    endtask

    function automatic logic [XLEN-1:0] model_result(opcode_e op, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b, logic [XLEN-1:0] imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_LI:   return imm;
            default: return a * b;
        endcase
    endfunction

    function automatic decoded_t make_instr(int w, opcode_e op, int rd, int rs1, int rs2,
                                            logic [XLEN-1:0] imm);
        decoded_t d;
        d.wid    = wid_t'(w);
        d.opcode = op;
        d.wb     = 1'b1;
        d.rd     = reg_t'(rd);
        d.rs1    = reg_t'(rs1);
        d.rs2    = reg_t'(rs2);
        d.imm    = imm;
        return d;
    endfunction

    // Pulses seen so far on the unit that serves this opcode
    function automatic int unit_pulses(opcode_e op);
        return (unit_of(op) == EX_MUL) ? mul_seen : alu_seen;
    endfunction

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            fail_run("timeout: the instructions did not drain in time");
        end
    end

    // The execution-unit model matches each pulse to its warp's oldest instruction
    task automatic take_dispatch();
        int      idx;
        int      delay;
        issued_t e;
        idx = -1;
        for (int i = 0; i < exp_q.size() && idx < 0; i++) begin
            if (exp_q[i].wid == ex_data.wid) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            fail_run("a dispatch appeared for a warp with nothing outstanding");
        end else begin
            e = exp_q[idx];
            exp_q.delete(idx);
            check_value("ex_data.opcode", XLEN'(ex_data.opcode), XLEN'(e.opcode));
            check_value("ex_data.rd", XLEN'(ex_data.rd), XLEN'(e.rd));
            check_value("ex_data.wb", XLEN'(ex_data.wb), XLEN'(e.wb));
            check_value("ex_data.imm", ex_data.imm, e.imm);
            check_value("mul_valid", XLEN'(mul_valid), XLEN'(unit_of(e.opcode) == EX_MUL));
            check_value("alu_valid", XLEN'(alu_valid), XLEN'(unit_of(e.opcode) == EX_ALU));
            // OP_LI sources are not hazard checked, so their values are don't care
            if (e.opcode != OP_LI) begin
                check_value("ex_data.rs1_data", ex_data.rs1_data, e.rs1_data);
                check_value("ex_data.rs2_data", ex_data.rs2_data, e.rs2_data);
            end
            if (mul_valid) begin
                mul_seen = mul_seen + 1;
            end else begin
                alu_seen = alu_seen + 1;
            end
            delay = 1 + int'($unsigned($random(seed)) % 4);
            fly_q.push_back(ex_data);
            fly_due.push_back(cycles + delay);
        end
    endtask

    // One writeback per cycle; the unit's credit comes back with it
    task automatic drive_writeback();
        int idx;
        idx = -1;
        wb_valid   = 1'b0;
        alu_credit = 1'b0;
        mul_credit = 1'b0;
        for (int i = 0; i < fly_q.size() && idx < 0; i++) begin
            if (cycles >= fly_due[i]) begin
                idx = i;
            end
        end
        if (!hold_wb && idx >= 0) begin
            wb_valid   = fly_q[idx].wb;
            wb_wid     = fly_q[idx].wid;
            wb_rd      = fly_q[idx].rd;
            wb_data    = model_result(fly_q[idx].opcode, fly_q[idx].rs1_data,
                                      fly_q[idx].rs2_data, fly_q[idx].imm);
            alu_credit = (unit_of(fly_q[idx].opcode) == EX_ALU);
            mul_credit = (unit_of(fly_q[idx].opcode) == EX_MUL);
            fly_q.delete(idx);
            fly_due.delete(idx);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (alu_valid || mul_valid) begin
                take_dispatch();
            end
            drive_writeback();
        end
    end

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_instr(input decoded_t d);
        issued_t e;
        logic    taken;
        e.wid      = d.wid;
        e.opcode   = d.opcode;
        e.wb       = d.wb;
        e.rd       = d.rd;
        e.imm      = d.imm;
        e.rs1_data = ref_rf[d.wid][d.rs1];
        e.rs2_data = ref_rf[d.wid][d.rs2];
        exp_q.push_back(e);
        if (d.wb) begin
            ref_rf[d.wid][d.rd] = model_result(d.opcode, e.rs1_data, e.rs2_data, d.imm);
        end
        dec_valid  = 1'b1;
        dec_data   = d;
        taken      = 1'b0;
        while (!taken) begin
            #1;
            taken = dec_ready;
            @(negedge clk);
        end
        dec_valid = 1'b0;
    endtask

    // Returns once every sent instruction was dispatched and written back
    task automatic wait_drain();
        while (exp_q.size() != 0 || fly_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            #1;
            check_value("alu_valid", XLEN'(alu_valid), '0);
            check_value("mul_valid", XLEN'(mul_valid), '0);
            check_value("dec_ready", XLEN'(dec_ready), XLEN'(1));
            @(negedge clk);
        end
    endtask

    task automatic dependence_chain();
        send_instr(make_instr(1, OP_LI, 1, 0, 0, 32'd5));
        send_instr(make_instr(1, OP_LI, 2, 0, 0, 32'd7));
        send_instr(make_instr(1, OP_ADD, 3, 1, 2, '0));
        send_instr(make_instr(1, OP_MUL, 4, 3, 1, '0));
        send_instr(make_instr(1, OP_SUB, 5, 4, 2, '0));
        send_instr(make_instr(1, OP_XOR, 1, 5, 3, '0));
        send_instr(make_instr(1, OP_MUL, 6, 1, 1, '0));
        wait_drain();
    endtask

    task automatic interleave_warps();
        for (int k = 1; k <= 3; k++) begin
            for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
                send_instr(make_instr(w, OP_LI, k, 0, 0, XLEN'(w * 100 + k)));
            end
        end
        for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
            send_instr(make_instr(w, OP_ADD, 4, 1, 2, '0));
            send_instr(make_instr(w, OP_MUL, 5, 2, 3, '0));
        end
        wait_drain();
    endtask

    // Runs the unit that serves op out of credits while writebacks are held
    task automatic credit_stall(input opcode_e op);
        decoded_t last;
        int       base;
        base    = unit_pulses(op);
        hold_wb = 1'b1;
        // Two at the unit, one in the collector and two buffered
        for (int r = 1; r <= 5; r++) begin
            send_instr(make_instr(0, op, r, 0, 0, XLEN'(200 + r)));
        end
        last      = make_instr(0, op, 6, 0, 0, 32'd206);
        dec_valid = 1'b1;
        dec_data  = last;
        repeat (12) begin
            @(negedge clk);
            #1;
            check_value("dec_ready", XLEN'(dec_ready), '0);
        end
        check_value("pulses while stalled", XLEN'(unit_pulses(op) - base),
                    XLEN'(`ISSUE_EX_CREDITS));
        hold_wb = 1'b0;
        @(negedge clk);
        send_instr(last);
        wait_drain();
        check_value("pulses after release", XLEN'(unit_pulses(op) - base), XLEN'(6));
    endtask

    task automatic random_mix();
        decoded_t d;
        int       w;
        int       rd;
        int       rs1;
        int       rs2;
        opcode_e  op;
        for (int i = 0; i < 150; i++) begin
            w   = int'($unsigned($random(seed)) % `ISSUE_NUM_WARPS);
            op  = opcode_e'(3'($unsigned($random(seed)) % 5));
            rd  = int'($unsigned($random(seed)) % `ISSUE_NUM_REGS);
            rs1 = int'($unsigned($random(seed)) % `ISSUE_NUM_REGS);
            rs2 = int'($unsigned($random(seed)) % `ISSUE_NUM_REGS);
            d   = make_instr(w, op, rd, rs1, rs2, $random(seed));
            // Roughly one in eight writes nothing back
            d.wb = ($unsigned($random(seed)) % 8) != 0;
            send_instr(d);
        end
        wait_drain();
        for (int v = 0; v < `ISSUE_NUM_WARPS; v++) begin
            for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
                d    = make_instr(v, OP_ADD, 0, r, 0, '0);
                d.wb = 1'b0;
                send_instr(d);
            end
        end
        wait_drain();
    endtask

    initial begin
        seed       = 32'hccce;
        rst        = 1'b1;
        dec_valid  = 1'b0;
        dec_data   = '0;
        hold_wb    = 1'b0;
        for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
            for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
                ref_rf[w][r] = '0;
            end
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        dependence_chain();
        interleave_warps();
        credit_stall(OP_LI);
        credit_stall(OP_MUL);
        random_mix();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* sim/issue_slice_chk.sv */
`include "issue_macros.svh"

module issue_slice_chk #(
    parameter int CNT_W = $clog2(`ISSUE_EX_CREDITS + 1)
) (
    input logic             clk,
    input logic             rst,
    input logic             alu_valid,
    input logic             mul_valid,
    input logic [CNT_W-1:0] alu_cnt,
    input logic [CNT_W-1:0] mul_cnt
);

    // The counter is charged in the cycle before the pulse shows up
    a_alu_credit: assert property (@(posedge clk) disable iff (rst)
        alu_valid |-> $past(alu_cnt) != '0)
        else $error("ALU pulse sent without a credit");

    a_mul_credit: assert property (@(posedge clk) disable iff (rst)
        mul_valid |-> $past(mul_cnt) != '0)
        else $error("MUL pulse sent without a credit");

    a_alu_max: assert property (@(posedge clk) disable iff (rst)
        alu_cnt <= CNT_W'(`ISSUE_EX_CREDITS))
        else $error("ALU credit counter above its initial value");

    a_mul_max: assert property (@(posedge clk) disable iff (rst)
        mul_cnt <= CNT_W'(`ISSUE_EX_CREDITS))
        else $error("MUL credit counter above its initial value");

    // ex_data is shared, so only one unit may take it per cycle
    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(alu_valid && mul_valid))
        else $error("ALU and MUL valid in the same cycle");

endmodule

bind dispatch_unit issue_slice_chk u_issue_slice_chk (
    .clk       (clk),
    .rst       (rst),
    .alu_valid (alu_valid),
    .mul_valid (mul_valid),
    .alu_cnt   (alu_cnt),
    .mul_cnt   (mul_cnt)
);

/* logic/issue_slice.sv */
`include "issue_macros.svh"

module issue_slice (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dec_valid,
    input  issue_instr_pkg::decoded_t dec_data,
    output logic                      dec_ready,
    input  logic                      wb_valid,
    input  issue_ctrl_pkg::wid_t      wb_wid,
    input  issue_ctrl_pkg::reg_t      wb_rd,
    input  logic [`ISSUE_XLEN-1:0]    wb_data,
    input  logic                      alu_credit,
    input  logic                      mul_credit,
    output logic                      alu_valid,
    output logic                      mul_valid,
    output issue_instr_pkg::issued_t  ex_data
);

    ibuf_if  ibuf ();
    sched_if sched ();
    opnd_if  opnd ();

    instr_buffer u_instr_buffer (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_data  (dec_data),
        .dec_ready (dec_ready),
        .ibuf      (ibuf.buffer)
    );

    // Writeback reaches both the hazard tracking and the register file
    scoreboard u_scoreboard (
        .clk      (clk),
        .rst      (rst),
        .wb_valid (wb_valid),
        .wb_wid   (wb_wid),
        .wb_rd    (wb_rd),
        .ibuf     (ibuf.sched),
        .sched    (sched.master)
    );

    operand_collector u_operand_collector (
        .clk      (clk),
        .rst      (rst),
        .wb_valid (wb_valid),
        .wb_wid   (wb_wid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .sched    (sched.slave),
        .opnd     (opnd.master)
    );

    dispatch_unit u_dispatch_unit (
        .clk        (clk),
        .rst        (rst),
        .opnd       (opnd.slave),
        .alu_credit (alu_credit),
        .mul_credit (mul_credit),
        .alu_valid  (alu_valid),
        .mul_valid  (mul_valid),
        .ex_data    (ex_data)
    );

endmodule

/* logic/dispatch_unit.sv */
`include "issue_macros.svh"

module dispatch_unit (
    input  logic                     clk,
    input  logic                     rst,
    opnd_if.slave                    opnd,
    input  logic                     alu_credit,
    input  logic                     mul_credit,
    output logic                     alu_valid,
    output logic                     mul_valid,
    output issue_instr_pkg::issued_t ex_data
);
    import issue_instr_pkg::*;

    localparam int CNT_W = $clog2(`ISSUE_EX_CREDITS + 1);

    logic [CNT_W-1:0] alu_cnt;
    logic [CNT_W-1:0] mul_cnt;
    ex_unit_e         unit;
    logic             has_credit;
    logic             fire;
    logic             alu_send;
    logic             mul_send;

    // Send and return in one cycle cancel out
    function automatic logic [CNT_W-1:0] next_cnt(logic [CNT_W-1:0] cnt, logic take,
                                                 logic give);
        case ({take, give})
            2'b10:   return cnt - 1'b1;
            2'b01:   return cnt + 1'b1;
            default: return cnt;
        endcase
    endfunction

    assign unit       = unit_of(opnd.data.opcode);
    assign has_credit = (unit == EX_ALU) ? (alu_cnt != '0) : (mul_cnt != '0);
    assign opnd.ready = has_credit;
    assign fire       = opnd.valid && opnd.ready;
    assign alu_send   = fire && (unit == EX_ALU);
    assign mul_send   = fire && (unit == EX_MUL);

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_cnt   <= CNT_W'(`ISSUE_EX_CREDITS);
            mul_cnt   <= CNT_W'(`ISSUE_EX_CREDITS);
            alu_valid <= 1'b0;
            mul_valid <= 1'b0;
        end else begin
            alu_cnt   <= next_cnt(alu_cnt, alu_send, alu_credit);
            mul_cnt   <= next_cnt(mul_cnt, mul_send, mul_credit);
            alu_valid <= alu_send;
            mul_valid <= mul_send;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            ex_data <= opnd.data;
        end
    end

endmodule

/* logic/operand_collector.sv */
`include "issue_macros.svh"

module operand_collector (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_valid,
    input  issue_ctrl_pkg::wid_t   wb_wid,
    input  issue_ctrl_pkg::reg_t   wb_rd,
    input  logic [`ISSUE_XLEN-1:0] wb_data,
    sched_if.slave                 sched,
    opnd_if.master                 opnd
);
    import issue_instr_pkg::*;
    import issue_ctrl_pkg::*;

    logic [`ISSUE_XLEN-1:0] rf [`ISSUE_NUM_WARPS][`ISSUE_NUM_REGS];

    oc_state_e              state;
    issued_t                out_q;
    logic [`ISSUE_XLEN-1:0] rs1_val;
    logic [`ISSUE_XLEN-1:0] rs2_val;
    logic                   rs1_fwd;
    logic                   rs2_fwd;
    logic                   in_fire;
    logic                   out_fire;

    // The register file of all warps is written by the writeback port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `ISSUE_NUM_WARPS; w++) begin
                for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
                    rf[w][r] <= '0;
                end
            end
        end else if (wb_valid) begin
            rf[wb_wid][wb_rd] <= wb_data;
        end
    end

    // Bypass the writeback that lands in the same cycle as the read
    assign rs1_fwd = wb_valid && (wb_wid == sched.data.wid) && (wb_rd == sched.data.rs1);
    assign rs2_fwd = wb_valid && (wb_wid == sched.data.wid) && (wb_rd == sched.data.rs2);
    assign rs1_val = rs1_fwd ? wb_data : rf[sched.data.wid][sched.data.rs1];
    assign rs2_val = rs2_fwd ? wb_data : rf[sched.data.wid][sched.data.rs2];

    assign opnd.valid  = (state == OC_FULL);
    assign opnd.data   = out_q;
    assign out_fire    = opnd.valid && opnd.ready;
    // The slot can be refilled in the cycle its contents leave
    assign sched.ready = (state == OC_EMPTY) || out_fire;
    assign in_fire     = sched.valid && sched.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= OC_EMPTY;
        end else begin
            case (state)
                OC_EMPTY: begin
                    if (in_fire) begin
                        state <= OC_FULL;
                    end
                end
                OC_FULL: begin
                    if (out_fire && !in_fire) begin
                        state <= OC_EMPTY;
                    end
                end
                default: state <= OC_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_q.wid      <= sched.data.wid;
            out_q.opcode   <= sched.data.opcode;
            out_q.wb       <= sched.data.wb;
            out_q.rd       <= sched.data.rd;
            out_q.imm      <= sched.data.imm;
            out_q.rs1_data <= rs1_val;
            out_q.rs2_data <= rs2_val;
        end
    end

endmodule

/* logic/scoreboard.sv */
`include "issue_macros.svh"

module scoreboard (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_valid,
    input  issue_ctrl_pkg::wid_t  wb_wid,
    input  issue_ctrl_pkg::reg_t  wb_rd,
    ibuf_if.sched                 ibuf,
    sched_if.master               sched
);
    import issue_instr_pkg::*;
    import issue_ctrl_pkg::*;

    localparam int NW = `ISSUE_NUM_WARPS;

    logic [NW-1:0][`ISSUE_NUM_REGS-1:0] pending;
    logic [NW-1:0][`ISSUE_NUM_REGS-1:0] pending_eff;
    logic [NW-1:0]                      eligible;
    wid_t                               last_wid;
    wid_t                               sel_wid;
    logic                               sel_found;
    logic                               fire;

    // A writeback this cycle already counts as done because the collector forwards it
    always_comb begin
        pending_eff = pending;
        if (wb_valid) begin
            pending_eff[wb_wid][wb_rd] = 1'b0;
        end
    end

    for (genvar w = 0; w < NW; w++) begin : g_hazard
        decoded_t head;
        logic     rd_busy;
        logic     rs_busy;

        assign head    = ibuf.head_data[w];
        assign rd_busy = head.wb && pending_eff[w][head.rd];
        // OP_LI takes its value from the immediate, so its sources never block
        assign rs_busy = (head.opcode != OP_LI) &&
                         (pending_eff[w][head.rs1] || pending_eff[w][head.rs2]);
        assign eligible[w] = ibuf.head_valid[w] && !rd_busy && !rs_busy;
    end

    // Round robin starting right after the warp that issued last
    always_comb begin
        int idx;
        sel_found = 1'b0;
        sel_wid   = '0;
        for (int k = 1; k <= NW; k++) begin
            idx = (int'(last_wid) + k) % NW;
            if (!sel_found && eligible[idx]) begin
                sel_found = 1'b1;
                sel_wid   = wid_t'(idx);
            end
        end
    end

    assign sched.valid = sel_found;
    assign sched.data  = ibuf.head_data[sel_wid];
    assign fire        = sched.valid && sched.ready;

    always_comb begin
        ibuf.pop          = '0;
        ibuf.pop[sel_wid] = fire;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= '0;
            last_wid <= wid_t'(NW - 1);
        end else begin
            pending <= pending_eff;
            if (fire && sched.data.wb) begin
                pending[sel_wid][sched.data.rd] <= 1'b1;
            end
            if (fire) begin
                last_wid <= sel_wid;
            end
        end
    end

endmodule

/* logic/instr_buffer.sv */
`include "issue_macros.svh"

module instr_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dec_valid,
    input  issue_instr_pkg::decoded_t dec_data,
    output logic                      dec_ready,
    ibuf_if.buffer                    ibuf
);
    import issue_instr_pkg::*;
    import issue_ctrl_pkg::*;

    localparam int DEPTH = `ISSUE_IBUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`ISSUE_NUM_WARPS-1:0] full;

    // Ready depends only on the FIFO the incoming warp id points at
    assign dec_ready = !full[dec_data.wid];

    for (genvar w = 0; w < `ISSUE_NUM_WARPS; w++) begin : g_warp
        decoded_t         mem [DEPTH];
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] wr_ptr;
        logic [CNT_W-1:0] count;
        logic             push;
        logic             pop;

        assign push = dec_valid && dec_ready && (dec_data.wid == wid_t'(w));
        assign pop  = ibuf.pop[w] && (count != '0);

        assign full[w]            = (count == CNT_W'(DEPTH));
        assign ibuf.head_valid[w] = (count != '0);
        assign ibuf.head_data[w]  = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= dec_data;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                // A push and a pop together leave the fill level alone
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

endmodule

/* logic/issue_ifs.sv */
`include "issue_macros.svh"

// Heads of all warp buffers toward the scoreboard, with a pop per warp
interface ibuf_if;
    import issue_instr_pkg::*;

    logic [`ISSUE_NUM_WARPS-1:0] head_valid;
    decoded_t                    head_data [`ISSUE_NUM_WARPS];
    logic [`ISSUE_NUM_WARPS-1:0] pop;

    modport buffer (
        output head_valid,
        output head_data,
        input  pop
    );

    modport sched (
        input  head_valid,
        input  head_data,
        output pop
    );
endinterface

// Selected instruction from the scoreboard to the operand collector
interface sched_if;
    import issue_instr_pkg::*;

    logic     valid;
    decoded_t data;
    logic     ready;

    modport master (output valid, output data, input ready);
    modport slave (input valid, input data, output ready);
endinterface

// Instruction with operands from the collector to dispatch
interface opnd_if;
    import issue_instr_pkg::*;

    logic    valid;
    issued_t data;
    logic    ready;

    modport master (output valid, output data, input ready);
    modport slave (input valid, input data, output ready);
endinterface

/* logic/issue_instr_pkg.sv */
`include "issue_macros.svh"

package issue_instr_pkg;

    import issue_ctrl_pkg::*;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_LI  = 3'd3,
        OP_MUL = 3'd4
    } opcode_e;

    typedef enum logic [0:0] {
        EX_ALU = 1'b0,
        EX_MUL = 1'b1
    } ex_unit_e;

    // Instruction as delivered by the front end
    typedef struct packed {
        wid_t                   wid;
        opcode_e                opcode;
        logic                   wb;
        reg_t                   rd;
        reg_t                   rs1;
        reg_t                   rs2;
        logic [`ISSUE_XLEN-1:0] imm;
    } decoded_t;

    // Instruction with its source values, as sent to an execution unit
    typedef struct packed {
        wid_t                   wid;
        opcode_e                opcode;
        logic                   wb;
        reg_t                   rd;
        logic [`ISSUE_XLEN-1:0] imm;
        logic [`ISSUE_XLEN-1:0] rs1_data;
        logic [`ISSUE_XLEN-1:0] rs2_data;
    } issued_t;

    // Only multiplies go to the MUL unit
    function automatic ex_unit_e unit_of(opcode_e op);
        return (op == OP_MUL) ? EX_MUL : EX_ALU;
    endfunction

endpackage

/* logic/issue_ctrl_pkg.sv */
`include "issue_macros.svh"

package issue_ctrl_pkg;

    // Index widths follow the warp and register counts
    localparam int WID_W = (`ISSUE_NUM_WARPS > 1) ? $clog2(`ISSUE_NUM_WARPS) : 1;
    localparam int REG_W = (`ISSUE_NUM_REGS > 1) ? $clog2(`ISSUE_NUM_REGS) : 1;

    // Warp index
    typedef logic [WID_W-1:0] wid_t;

    // Register index within one warp
    typedef logic [REG_W-1:0] reg_t;

    // The collector holds at most one instruction
    typedef enum logic {
        OC_EMPTY = 1'b0,
        OC_FULL  = 1'b1
    } oc_state_e;

endpackage

/* logic/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Number of warps sharing this issue slice
`define ISSUE_NUM_WARPS 4

// Architectural registers per warp
`define ISSUE_NUM_REGS 8

// Width of one lane's data path
`define ISSUE_XLEN 32

// Entries in each per-warp instruction buffer
`define ISSUE_IBUF_DEPTH 2

// Credits each execution unit starts with after reset
`define ISSUE_EX_CREDITS 2

`endif
